// File: compile.f
hw/pll_drp_pkg.sv
hw/drp_step_table.sv
hw/drp_rmw_fsm.sv
hw/pll_reconfig_top.sv
tb/pll_reconfig_assert.sv
tb/pll_reconfig_check.sv
tb/tb_pll_reconfig.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_pll_reconfig
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "=== PASS ===" $(LOG); then echo "Simulation gave no result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb/tb_pll_reconfig.sv
`timescale 1ns/100ps

module tb_pll_reconfig;

   logic                  dclk = 1'b0;
   logic                  rst;
   pll_drp_pkg::pll_cfg_t cfg;
   logic                  start_reconfig;
   logic                  ready;
   logic                  reconfig_done;
   pll_drp_pkg::drp_req_t drp_req;
   pll_drp_pkg::drp_rsp_t drp_rsp;
   logic                  rst_pll;
   logic                  locked;
   int                    checks;
   int                    errors;
   int                    sequences;
   logic [31:0]           model_rng;
   logic [31:0]           stim_rng;
   logic [15:0]           regs [0:127];

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   always #10 dclk = ~dclk;

   pll_reconfig_top dut0 (.*);

   pll_reconfig_check chk0 (.*);

   task automatic randomize_cfg();
      logic [95:0] bits;
      bits = '0;
      for (int i = 0; i < 3; i++) begin
         stim_rng = xorshift32(stim_rng);
         bits     = {bits[63:0], stim_rng};
      end
      cfg = bits[82:0];
   endtask

   // DRP register file with random drdy delay, and the PLL lock
   initial begin
      int         wait_cnt;
      int         lock_cnt;
      logic       busy;
      logic [6:0] rd_addr;
      drp_rsp   = '0;
      locked    = 1'b0;
      busy      = 1'b0;
      wait_cnt  = 0;
      lock_cnt  = 0;
      rd_addr   = '0;
      model_rng = 32'h3310e3ac;
      for (int a = 0; a < 128; a++) begin
         model_rng = xorshift32(model_rng);
         regs[a]   = {model_rng[15:7], model_rng[6:0] ^ 7'(a)};
      end
      forever begin
         @(negedge dclk);
         drp_rsp.drdy = 1'b0;
         if (busy && wait_cnt == 0) begin
            drp_rsp.drdy = 1'b1;
            drp_rsp.dout = regs[rd_addr];
            busy         = 1'b0;
         end else if (busy) begin
            wait_cnt--;
         end
         if (drp_req.den) begin
            model_rng = xorshift32(model_rng);
            busy      = 1'b1;
            rd_addr   = drp_req.daddr;
            wait_cnt  = int'(model_rng[1:0]);
            if (drp_req.dwe)
               regs[drp_req.daddr] = drp_req.din;
         end
         if (rst_pll) begin
            model_rng = xorshift32(model_rng);
            locked    = 1'b0;
            lock_cnt  = 2 + int'(model_rng % 32'd5);
         end else if (lock_cnt > 0) begin
            lock_cnt--;
            locked = (lock_cnt == 0);
         end
      end
   end

   initial begin
      rst            = 1'b1;
      start_reconfig = 1'b0;
      stim_rng       = ~32'h3310e3ac;
      randomize_cfg();
      repeat (2) @(posedge dclk);
      @(negedge dclk);
      rst = 1'b0;
      // Start while the PLL is still locking
      @(negedge dclk);
      start_reconfig = 1'b1;
      @(negedge dclk);
      start_reconfig = 1'b0;
      for (int s = 0; s < 3; s++) begin
         while (!ready) @(negedge dclk);
         randomize_cfg();
         start_reconfig = 1'b1;
         @(negedge dclk);
         start_reconfig = 1'b0;
         if (s == 1) begin
            repeat (20) @(negedge dclk);
            randomize_cfg();
         end
         while (!reconfig_done) @(negedge dclk);
      end
      while (!ready) @(negedge dclk);
      @(negedge dclk);
      if (sequences != 3)
         $display("Expected three completed sequences but saw %0d", sequences);
      $display("Checks %0d, errors %0d, assertion failures %0d, sequences %0d", checks,
               errors, dut0.u_rmw_fsm.u_drp_assert.fail_count, sequences);
      if (errors == 0 && sequences == 3 && dut0.u_rmw_fsm.u_drp_assert.fail_count == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

   // Three sequences of eight steps at up to 14 cycles, plus reset and lock time
   initial begin
      repeat (3 * pll_drp_pkg::NUM_STEPS * 14 + 300) @(posedge dclk);
      $display("Timeout: the sequences did not complete in time");
      $display("=== FAIL ===");
      $finish;
   end

endmodule

// File: tb/pll_reconfig_check.sv
`timescale 1ns/100ps

module pll_reconfig_check (
   input  logic                  dclk,
   input  logic                  rst,
   input  pll_drp_pkg::pll_cfg_t cfg,
   input  logic                  start_reconfig,
   input  logic                  ready,
   input  logic                  reconfig_done,
   input  pll_drp_pkg::drp_req_t drp_req,
   input  pll_drp_pkg::drp_rsp_t drp_rsp,
   input  logic                  rst_pll,
   input  logic                  locked,
   output int                    checks,
   output int                    errors,
   output int                    sequences
);

   pll_drp_pkg::pll_cfg_t cap_cfg;
   logic [6:0]            rd_addr;
   logic [15:0]           rd_val;
   logic                  in_seq = 1'b0;
   logic                  rst_q = 1'b0;
   logic                  ready_q = 1'b0;
   logic                  locked_q = 1'b0;
   int                    step_idx;
   // 0 read due, 1 read pending, 2 write due, 3 write pending
   int                    phase;

   function automatic logic [6:0] step_addr(input int s);
      case (s)
         0: return pll_drp_pkg::ADDR_POWER;
         1: return pll_drp_pkg::ADDR_CLKOUT0_REG1;
         2: return pll_drp_pkg::ADDR_CLKOUT0_REG2;
         3: return pll_drp_pkg::ADDR_CLKOUT1_REG1;
         4: return pll_drp_pkg::ADDR_CLKOUT1_REG2;
         5: return pll_drp_pkg::ADDR_CLKFBOUT_REG1;
         6: return pll_drp_pkg::ADDR_CLKFBOUT_REG2;
         default: return pll_drp_pkg::ADDR_DIVCLK;
      endcase
   endfunction

   // Read value through the step mask, then the field word from the captured request
   function automatic logic [15:0] rmw_word(input int s, input logic [15:0] rd,
                                            input pll_drp_pkg::pll_cfg_t c);
      pll_drp_pkg::clkout_cfg_t k;
      logic [15:0]              m;
      logic [15:0]              f;
      k = (s < 3) ? c.clkout0 : ((s < 5) ? c.clkout1 : c.clkfbout);
      if (s == 0) begin
         m = pll_drp_pkg::MASK_POWER;
         f = 16'hFFFF;
      end else if (s == 7) begin
         m = pll_drp_pkg::MASK_DIVCLK;
         f = {2'b00, c.divclk.edge_sel, c.divclk.no_count,
              c.divclk.high_time, c.divclk.low_time};
      end else if (s % 2 == 1) begin
         m = pll_drp_pkg::MASK_REG1;
         f = {k.phase_mux, 1'b0, k.high_time, k.low_time};
      end else begin
         m = pll_drp_pkg::MASK_REG2;
         f = {8'h00, k.edge_sel, k.no_count, k.delay_time};
      end
      return (rd & m) | f;
   endfunction

   task automatic note_error(input string msg);
      errors++;
      $display("%s", msg);
   endtask

   always @(posedge dclk) begin
      if (rst_q) begin
         checks++;
         if (drp_req.den || drp_req.dwe || ready || reconfig_done)
            note_error($sformatf("ERR %0t: outputs not idle after reset", $time));
      end
      if (rst) begin
         in_seq   = 1'b0;
         phase    = 0;
         step_idx = 0;
      end else begin
         if (ready && !ready_q && !locked_q)
            note_error($sformatf("ERR %0t: ready rose without lock", $time));
         if (ready && start_reconfig) begin
            cap_cfg  = cfg;
            in_seq   = 1'b1;
            step_idx = 0;
            phase    = 0;
         end
         if (drp_req.den) begin
            checks++;
            if (!in_seq) begin
               note_error("A DRP transaction was issued outside a sequence");
            end else if (phase == 1 || phase == 3) begin
               note_error("A DRP transaction was issued before the previous one finished");
            end else if (!drp_req.dwe) begin
               if (phase != 0 || drp_req.daddr != step_addr(step_idx))
                  note_error($sformatf("ERR %0t: read of %h at step %0d", $time,
                                       drp_req.daddr, step_idx));
               rd_addr = drp_req.daddr;
               phase   = 1;
            end else begin
               if (phase != 2 || drp_req.daddr != rd_addr)
                  note_error($sformatf("ERR %0t: write to %h, last read %h", $time,
                                       drp_req.daddr, rd_addr));
               else if (drp_req.din != rmw_word(step_idx, rd_val, cap_cfg))
                  note_error($sformatf("ERR %0t: step %0d wrote %h, expected %h", $time,
                                       step_idx, drp_req.din,
                                       rmw_word(step_idx, rd_val, cap_cfg)));
               phase = 3;
            end
         end
         if (drp_rsp.drdy && phase == 1) begin
            rd_val = drp_rsp.dout;
            phase  = 2;
         end else if (drp_rsp.drdy && phase == 3) begin
            step_idx++;
            phase = 0;
         end
         if (reconfig_done) begin
            checks++;
            if (!in_seq || step_idx != pll_drp_pkg::NUM_STEPS || rst_pll)
               note_error("The done pulse came outside the end of a sequence");
            in_seq = 1'b0;
            sequences++;
         end else if (in_seq && (step_idx > 0 || phase != 0) && !rst_pll) begin
            note_error("The PLL reset dropped in the middle of a sequence");
         end
      end
      rst_q    = rst;
      ready_q  = ready;
      locked_q = locked;
   end

endmodule

// File: tb/pll_reconfig_assert.sv
`timescale 1ns/100ps

module pll_reconfig_assert (
   input logic                  dclk,
   input logic                  rst,
   input pll_drp_pkg::drp_req_t drp_req,
   input pll_drp_pkg::drp_rsp_t drp_rsp,
   input logic                  reconfig_done
);

   logic outstanding;
   int   fail_count = 0;

   always_ff @(posedge dclk) begin
      if (rst) begin
         outstanding <= 1'b0;
      end else if (drp_req.den) begin
         outstanding <= 1'b1;
      end else if (drp_rsp.drdy) begin
         outstanding <= 1'b0;
      end
   end

   den_single: assert property (@(posedge dclk) disable iff (rst)
      drp_req.den |=> !drp_req.den)
      else begin
         fail_count++;
         $error("den high for more than one cycle");
      end

   dwe_with_den: assert property (@(posedge dclk) disable iff (rst)
      drp_req.dwe |-> drp_req.den)
      else begin
         fail_count++;
         $error("dwe high without den");
      end

   one_outstanding: assert property (@(posedge dclk) disable iff (rst)
      drp_req.den |-> !outstanding)
      else begin
         fail_count++;
         $error("den while a transaction is outstanding");
      end

   done_single: assert property (@(posedge dclk) disable iff (rst)
      reconfig_done |=> !reconfig_done)
      else begin
         fail_count++;
         $error("reconfig_done high for more than one cycle");
      end

endmodule

bind drp_rmw_fsm pll_reconfig_assert u_drp_assert (
   .dclk          (dclk),
   .rst           (rst),
   .drp_req       (drp_req),
   .drp_rsp       (drp_rsp),
   .reconfig_done (reconfig_done)
);

// File: hw/pll_reconfig_top.sv
`timescale 1ns/100ps

module pll_reconfig_top (
   input  logic                  dclk,
   input  logic                  rst,
   input  pll_drp_pkg::pll_cfg_t cfg,
   input  logic                  start_reconfig,
   output logic                  ready,
   output logic                  reconfig_done,
   output pll_drp_pkg::drp_req_t drp_req,
   input  pll_drp_pkg::drp_rsp_t drp_rsp,
   output logic                  rst_pll,
   input  logic                  locked
);

   pll_drp_pkg::cfg_step_e             step;
   logic                               capture;
   logic [pll_drp_pkg::DRP_ADDR_W-1:0] addr;
   logic [pll_drp_pkg::DRP_DATA_W-1:0] mask;
   logic [pll_drp_pkg::DRP_DATA_W-1:0] field;

   drp_step_table u_step_table (
      .dclk    (dclk),
      .rst     (rst),
      .cfg     (cfg),
      .capture (capture),
      .step    (step),
      .addr    (addr),
      .mask    (mask),
      .field   (field)
   );

   drp_rmw_fsm u_rmw_fsm (
      .dclk           (dclk),
      .rst            (rst),
      .start_reconfig (start_reconfig),
      .locked         (locked),
      .addr           (addr),
      .mask           (mask),
      .field          (field),
      .step           (step),
      .capture        (capture),
      .drp_req        (drp_req),
      .drp_rsp        (drp_rsp),
      .rst_pll        (rst_pll),
      .ready          (ready),
      .reconfig_done  (reconfig_done)
   );

endmodule

// File: hw/drp_rmw_fsm.sv
`timescale 1ns/100ps

module drp_rmw_fsm (
   input  logic                               dclk,
   input  logic                               rst,
   input  logic                               start_reconfig,
   input  logic                               locked,
   input  logic [pll_drp_pkg::DRP_ADDR_W-1:0] addr,
   input  logic [pll_drp_pkg::DRP_DATA_W-1:0] mask,
   input  logic [pll_drp_pkg::DRP_DATA_W-1:0] field,
   output pll_drp_pkg::cfg_step_e             step,
   output logic                               capture,
   output pll_drp_pkg::drp_req_t              drp_req,
   input  pll_drp_pkg::drp_rsp_t              drp_rsp,
   output logic                               rst_pll,
   output logic                               ready,
   output logic                               reconfig_done
);

   pll_drp_pkg::drp_state_e state;

   logic                               den_q;
   logic                               dwe_q;
   logic [pll_drp_pkg::DRP_ADDR_W-1:0] daddr_q;
   logic [pll_drp_pkg::DRP_DATA_W-1:0] din_q;
   logic [pll_drp_pkg::DRP_DATA_W-1:0] rd_data;

   // Start only counts while idle and ready
   assign capture = ready & start_reconfig;

   assign drp_req = '{den: den_q, dwe: dwe_q, daddr: daddr_q, din: din_q};

   always_ff @(posedge dclk) begin
      if (rst) begin
         state         <= pll_drp_pkg::ST_RESTART;
         step          <= pll_drp_pkg::STEP_POWER;
         den_q         <= 1'b0;
         dwe_q         <= 1'b0;
         rst_pll       <= 1'b0;
         ready         <= 1'b0;
         reconfig_done <= 1'b0;
      end else begin
         den_q         <= 1'b0;
         dwe_q         <= 1'b0;
         ready         <= 1'b0;
         reconfig_done <= 1'b0;
         case (state)
            pll_drp_pkg::ST_RESTART: begin
               rst_pll <= 1'b1;
               step    <= pll_drp_pkg::STEP_POWER;
               state   <= pll_drp_pkg::ST_WAIT_LOCK;
            end
            pll_drp_pkg::ST_WAIT_LOCK: begin
               rst_pll <= 1'b0;
               // Ignore a stale lock while the PLL is still held in reset
               if (locked && !rst_pll) begin
                  ready <= 1'b1;
                  state <= pll_drp_pkg::ST_WAIT_START;
               end
            end
            pll_drp_pkg::ST_WAIT_START: begin
               if (capture) begin
                  state <= pll_drp_pkg::ST_ADDRESS;
               end else begin
                  ready <= 1'b1;
               end
            end
            pll_drp_pkg::ST_ADDRESS: begin
               rst_pll <= 1'b1;
               den_q   <= 1'b1;
               state   <= pll_drp_pkg::ST_WAIT_A_DRDY;
            end
            pll_drp_pkg::ST_WAIT_A_DRDY: begin
               if (drp_rsp.drdy) begin
                  state <= pll_drp_pkg::ST_BITMASK;
               end
            end
            pll_drp_pkg::ST_BITMASK: begin
               state <= pll_drp_pkg::ST_BITSET;
            end
            pll_drp_pkg::ST_BITSET: begin
               state <= pll_drp_pkg::ST_WRITE;
            end
            pll_drp_pkg::ST_WRITE: begin
               den_q <= 1'b1;
               dwe_q <= 1'b1;
               state <= pll_drp_pkg::ST_WAIT_DRDY;
            end
            pll_drp_pkg::ST_WAIT_DRDY: begin
               if (drp_rsp.drdy) begin
                  if (int'(step) == pll_drp_pkg::NUM_STEPS - 1) begin
                     // Table done, let the PLL relock
                     step          <= pll_drp_pkg::STEP_POWER;
                     rst_pll       <= 1'b0;
                     reconfig_done <= 1'b1;
                     state         <= pll_drp_pkg::ST_WAIT_LOCK;
                  end else begin
                     step  <= step.next();
                     state <= pll_drp_pkg::ST_ADDRESS;
                  end
               end
            end
            default: begin
               state <= pll_drp_pkg::ST_RESTART;
            end
         endcase
      end
   end

   // Address and data path of the read-modify-write
   always_ff @(posedge dclk) begin
      case (state)
         pll_drp_pkg::ST_ADDRESS: begin
            daddr_q <= addr;
         end
         pll_drp_pkg::ST_WAIT_A_DRDY: begin
            // dout is only valid alongside drdy
            if (drp_rsp.drdy) begin
               rd_data <= drp_rsp.dout;
            end
         end
         pll_drp_pkg::ST_BITMASK: begin
            din_q <= rd_data & mask;
         end
         pll_drp_pkg::ST_BITSET: begin
            din_q <= din_q | field;
         end
         default: begin
         end
      endcase
   end

endmodule

// File: hw/drp_step_table.sv
`timescale 1ns/100ps

module drp_step_table (
   input  logic                               dclk,
   input  logic                               rst,
   input  pll_drp_pkg::pll_cfg_t              cfg,
   input  logic                               capture,
   input  pll_drp_pkg::cfg_step_e             step,
   output logic [pll_drp_pkg::DRP_ADDR_W-1:0] addr,
   output logic [pll_drp_pkg::DRP_DATA_W-1:0] mask,
   output logic [pll_drp_pkg::DRP_DATA_W-1:0] field
);

   pll_drp_pkg::pll_cfg_t cfg_q;

   // Counter register 1: phase mux, high and low time
   function automatic logic [pll_drp_pkg::DRP_DATA_W-1:0] reg1_word(
      input pll_drp_pkg::clkout_cfg_t c
   );
      return {c.phase_mux, 1'b0, c.high_time, c.low_time};
   endfunction

   // Counter register 2: edge, no count, delay
   function automatic logic [pll_drp_pkg::DRP_DATA_W-1:0] reg2_word(
      input pll_drp_pkg::clkout_cfg_t c
   );
      return {8'h00, c.edge_sel, c.no_count, c.delay_time};
   endfunction

   function automatic logic [pll_drp_pkg::DRP_DATA_W-1:0] div_word(
      input pll_drp_pkg::divclk_cfg_t d
   );
      return {2'b00, d.edge_sel, d.no_count, d.high_time, d.low_time};
   endfunction

   // Snapshot keeps the sequence stable if cfg moves
   always_ff @(posedge dclk) begin
      if (rst) begin
         cfg_q <= '0;
      end else if (capture) begin
         cfg_q <= cfg;
      end
   end

   always_comb begin
      addr  = pll_drp_pkg::ADDR_POWER;
      mask  = pll_drp_pkg::MASK_POWER;
      field = pll_drp_pkg::POWER_WORD;
      case (step)
         pll_drp_pkg::STEP_POWER: begin
            addr  = pll_drp_pkg::ADDR_POWER;
            mask  = pll_drp_pkg::MASK_POWER;
            field = pll_drp_pkg::POWER_WORD;
         end
         pll_drp_pkg::STEP_CLKOUT0_REG1: begin
            addr  = pll_drp_pkg::ADDR_CLKOUT0_REG1;
            mask  = pll_drp_pkg::MASK_REG1;
            field = reg1_word(cfg_q.clkout0);
         end
         pll_drp_pkg::STEP_CLKOUT0_REG2: begin
            addr  = pll_drp_pkg::ADDR_CLKOUT0_REG2;
            mask  = pll_drp_pkg::MASK_REG2;
            field = reg2_word(cfg_q.clkout0);
         end
         pll_drp_pkg::STEP_CLKOUT1_REG1: begin
            addr  = pll_drp_pkg::ADDR_CLKOUT1_REG1;
            mask  = pll_drp_pkg::MASK_REG1;
            field = reg1_word(cfg_q.clkout1);
         end
         pll_drp_pkg::STEP_CLKOUT1_REG2: begin
            addr  = pll_drp_pkg::ADDR_CLKOUT1_REG2;
            mask  = pll_drp_pkg::MASK_REG2;
            field = reg2_word(cfg_q.clkout1);
         end
         pll_drp_pkg::STEP_CLKFBOUT_REG1: begin
            addr  = pll_drp_pkg::ADDR_CLKFBOUT_REG1;
            mask  = pll_drp_pkg::MASK_REG1;
            field = reg1_word(cfg_q.clkfbout);
         end
         pll_drp_pkg::STEP_CLKFBOUT_REG2: begin
            addr  = pll_drp_pkg::ADDR_CLKFBOUT_REG2;
            mask  = pll_drp_pkg::MASK_REG2;
            field = reg2_word(cfg_q.clkfbout);
         end
         pll_drp_pkg::STEP_DIVCLK: begin
            addr  = pll_drp_pkg::ADDR_DIVCLK;
            mask  = pll_drp_pkg::MASK_DIVCLK;
            field = div_word(cfg_q.divclk);
         end
         default: begin
            addr  = pll_drp_pkg::ADDR_POWER;
            mask  = pll_drp_pkg::MASK_POWER;
            field = pll_drp_pkg::POWER_WORD;
         end
      endcase
   end

endmodule

// File: hw/pll_drp_pkg.sv
package pll_drp_pkg;

   localparam int DRP_ADDR_W = 7;
   localparam int DRP_DATA_W = 16;
   localparam int NUM_STEPS  = 8;
   localparam int STEP_W     = 3;

   // Register steps in the order they are written
   typedef enum logic [STEP_W-1:0] {
      STEP_POWER,
      STEP_CLKOUT0_REG1,
      STEP_CLKOUT0_REG2,
      STEP_CLKOUT1_REG1,
      STEP_CLKOUT1_REG2,
      STEP_CLKFBOUT_REG1,
      STEP_CLKFBOUT_REG2,
      STEP_DIVCLK
   } cfg_step_e;

   // PLL register addresses
   localparam logic [DRP_ADDR_W-1:0] ADDR_POWER         = 7'h28;
   localparam logic [DRP_ADDR_W-1:0] ADDR_CLKOUT0_REG1  = 7'h08;
   localparam logic [DRP_ADDR_W-1:0] ADDR_CLKOUT0_REG2  = 7'h09;
   localparam logic [DRP_ADDR_W-1:0] ADDR_CLKOUT1_REG1  = 7'h0A;
   localparam logic [DRP_ADDR_W-1:0] ADDR_CLKOUT1_REG2  = 7'h0B;
   localparam logic [DRP_ADDR_W-1:0] ADDR_CLKFBOUT_REG1 = 7'h14;
   localparam logic [DRP_ADDR_W-1:0] ADDR_CLKFBOUT_REG2 = 7'h15;
   localparam logic [DRP_ADDR_W-1:0] ADDR_DIVCLK        = 7'h16;

   // Bits kept from the read value
   localparam logic [DRP_DATA_W-1:0] MASK_POWER  = 16'h0000;
   localparam logic [DRP_DATA_W-1:0] MASK_REG1   = 16'h1000;
   localparam logic [DRP_DATA_W-1:0] MASK_REG2   = 16'hFC00;
   localparam logic [DRP_DATA_W-1:0] MASK_DIVCLK = 16'hC000;

   localparam logic [DRP_DATA_W-1:0] POWER_WORD = 16'hFFFF;

   // One output or feedback counter
   typedef struct packed {
      logic [2:0] phase_mux;
      logic [5:0] high_time;
      logic [5:0] low_time;
      logic       edge_sel;
      logic       no_count;
      logic [5:0] delay_time;
   } clkout_cfg_t;

   // Input divider
   typedef struct packed {
      logic [5:0] high_time;
      logic [5:0] low_time;
      logic       edge_sel;
      logic       no_count;
   } divclk_cfg_t;

   typedef struct packed {
      clkout_cfg_t clkout0;
      clkout_cfg_t clkout1;
      clkout_cfg_t clkfbout;
      divclk_cfg_t divclk;
   } pll_cfg_t;

   typedef struct packed {
      logic                  den;
      logic                  dwe;
      logic [DRP_ADDR_W-1:0] daddr;
      logic [DRP_DATA_W-1:0] din;
   } drp_req_t;

   typedef struct packed {
      logic [DRP_DATA_W-1:0] dout;
      logic                  drdy;
   } drp_rsp_t;

   typedef enum logic [3:0] {
      ST_RESTART,
      ST_WAIT_LOCK,
      ST_WAIT_START,
      ST_ADDRESS,
      ST_WAIT_A_DRDY,
      ST_BITMASK,
      ST_BITSET,
      ST_WRITE,
      ST_WAIT_DRDY
   } drp_state_e;

endpackage
